// ==== Makefile ====
# Verilator build and run for the TCB subsystem
# a failing run ends in $fatal, so make returns a failing status

VERILATOR ?= verilator
TB_TOP    ?= tcb_sys_tb
RTL_TOP   ?= tcb_sys
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing

SOURCES := $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TB_TOP)

$(BUILD_DIR)/V$(TB_TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TB_TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== hw/tcb_csr.sv ====
//////////////////////////////
// TCB control and status registers
// memory wait states, write protection limit
// and a saturating error counter
//////////////////////////////

`timescale 1ns/10ps

module tcb_csr import tcb_pkg::*; (
  input  logic tcb,
  input  logic rst_n,
  // request
  input  logic vld,
  input  logic wen,
  input  adr_t adr,
  input  ben_t ben,
  input  dat_t wdt,
  output logic rdy,
  // response
  output logic rsp,
  output dat_t rdt,
  // memory control
  output wst_t wst,
  output wix_t wpl,
  // error response pulse
  input  logic err_evt
);

  logic trn;
  logic [CSR_AW-3:0] wof;
  dat_t errc;
  dat_t errc_nxt;
  dat_t rmux;

  // never stalls
  assign rdy = vld;
  assign trn = vld & rdy;

  // word offset, byte bits ignored
  assign wof = adr[CSR_AW-1:2];

//////////////////////////////
// registers
//////////////////////////////

  always_ff @(posedge tcb or negedge rst_n) begin
    if (!rst_n) begin
      wst <= '0;
      wpl <= '0;
    end else if (trn & wen) begin
      // both fields live in byte lane 0
      if (wof == CSR_CTRL[CSR_AW-1:2] && ben[0]) wst <= wdt[1:0];
      if (wof == CSR_WPL[CSR_AW-1:2] && ben[0]) wpl <= wdt[7:0];
    end
  end

  // count up, stick at all ones
  assign errc_nxt = (err_evt && errc != '1) ? errc + 1'b1 : errc;

  always_ff @(posedge tcb or negedge rst_n) begin
    if (!rst_n) begin
      errc <= '0;
    end else begin
      errc <= errc_nxt;
    end
  end

//////////////////////////////
// read path
//////////////////////////////

  // counter read includes an error pulse of this cycle
  always_comb begin
    rmux = '0;
    case (wof)
      CSR_CTRL[CSR_AW-1:2]: rmux[1:0] = wst;
      CSR_WPL[CSR_AW-1:2]:  rmux[7:0] = wpl;
      CSR_ERRC[CSR_AW-1:2]: rmux = errc_nxt;
      default:              rmux = '0;
    endcase
  end

  always_ff @(posedge tcb) begin
    if (trn) rdt <= rmux;
  end

  always_ff @(posedge tcb or negedge rst_n) begin
    if (!rst_n) begin
      rsp <= 1'b0;
    end else begin
      rsp <= trn;
    end
  end

endmodule: tcb_csr

// ==== hw/tcb_dec.sv ====
//////////////////////////////
// TCB address decoder
// routes the handshake to memory or registers, answers
// unmapped accesses itself and muxes the responses
//////////////////////////////

`timescale 1ns/10ps

module tcb_dec import tcb_pkg::*; (
  input  logic tcb,
  input  logic rst_n,
  // manager request
  input  logic vld,
  input  logic wen,
  input  adr_t adr,
  // target handshake
  output logic mem_vld,
  output logic csr_vld,
  input  logic mem_rdy,
  input  logic csr_rdy,
  // target responses
  input  logic mem_rsp,
  input  dat_t mem_rdt,
  input  logic mem_err,
  input  logic csr_rsp,
  input  dat_t csr_rdt,
  // manager response
  output logic rdy,
  output logic rsp,
  output dat_t rdt,
  output logic err,
  // error pulse toward the counter
  output logic err_evt
);

  logic mem_sel;
  logic csr_sel;
  logic unm_sel;
  // pending decoder side responses
  logic unm_q;
  logic wce_q;

//////////////////////////////
// request routing
//////////////////////////////

  // region match on upper address bits
  assign mem_sel = (adr[ABW-1:MEM_AW] == MEM_BASE[ABW-1:MEM_AW]);
  assign csr_sel = (adr[ABW-1:CSR_AW] == CSR_BASE[ABW-1:CSR_AW]);
  assign unm_sel = ~mem_sel & ~csr_sel;

  assign mem_vld = vld & mem_sel;
  assign csr_vld = vld & csr_sel;

  // unmapped requests never stall
  assign rdy = mem_sel ? mem_rdy :
               csr_sel ? csr_rdy : 1'b1;

  // response select flops
  always_ff @(posedge tcb or negedge rst_n) begin
    if (!rst_n) begin
      unm_q <= 1'b0;
      wce_q <= 1'b0;
    end else begin
      unm_q <= vld & rdy & unm_sel;
      // write to the read-only error counter
      wce_q <= csr_vld & csr_rdy & wen & (adr[CSR_AW-1:2] == CSR_ERRC[CSR_AW-1:2]);
    end
  end

//////////////////////////////
// response mux
//////////////////////////////

  assign rsp = mem_rsp | csr_rsp | unm_q;

  // unmapped reads return zero
  assign rdt = mem_rsp ? mem_rdt :
               csr_rsp ? csr_rdt : '0;

  assign err = (mem_rsp & mem_err) | wce_q | unm_q;

  // one pulse per error response
  assign err_evt = rsp & err;

  // at most one source answers in a cycle
  assert property (@(posedge tcb) disable iff (!rst_n)
    $onehot0({mem_rsp, csr_rsp, unm_q}));

endmodule: tcb_dec

// ==== hw/tcb_mem.sv ====
//////////////////////////////
// TCB byte-enabled memory
// wait states before accept, writes below the
// protection limit are refused with an error
//////////////////////////////

`timescale 1ns/10ps

module tcb_mem import tcb_pkg::*; (
  input  logic tcb,
  input  logic rst_n,
  // request
  input  logic vld,
  input  logic wen,
  input  adr_t adr,
  input  ben_t ben,
  input  dat_t wdt,
  output logic rdy,
  // control from registers
  input  wst_t wst,
  input  wix_t wpl,
  // response
  output logic rsp,
  output dat_t rdt,
  output logic err
);

  dat_t mem [MEM_WORDS];
  wix_t wix;
  wst_t wcnt;
  logic trn;
  logic prot;

  // word index from byte address
  assign wix = adr[MEM_AW-1:2];
  // words below the limit are write protected
  assign prot = (wix < wpl);

//////////////////////////////
// wait states
//////////////////////////////

  // ready once vld was held for wst cycles
  assign rdy = vld & (wcnt == wst);
  assign trn = vld & rdy;

  always_ff @(posedge tcb or negedge rst_n) begin
    if (!rst_n) begin
      wcnt <= '0;
    end else if (trn) begin
      wcnt <= '0;
    end else if (vld) begin
      wcnt <= wcnt + 2'd1;
    end
  end

//////////////////////////////
// array and response
//////////////////////////////

  // byte lane writes, rejected writes change nothing
  always_ff @(posedge tcb) begin
    if (trn & wen & ~prot) begin
      for (int i = 0; i < BEW; i++) begin
        if (ben[i]) mem[wix][8*i +: 8] <= wdt[8*i +: 8];
      end
    end
  end

  // read data held for the response cycle
  always_ff @(posedge tcb) begin
    if (trn & ~wen) rdt <= mem[wix];
  end

  always_ff @(posedge tcb or negedge rst_n) begin
    if (!rst_n) begin
      rsp <= 1'b0;
      err <= 1'b0;
    end else begin
      rsp <= trn;
      err <= trn & wen & prot;
    end
  end

  // a waiting request is held unchanged
  assert property (@(posedge tcb) disable iff (!rst_n)
    vld & ~rdy |=> vld && $stable(wen) && $stable(adr) && $stable(ben) && $stable(wdt));

  // ready only after wst cycles of pending vld
  assert property (@(posedge tcb) disable iff (!rst_n)
    rdy |-> (wst < 2'd1 || $past(vld & ~rdy, 1))
         && (wst < 2'd2 || $past(vld & ~rdy, 2))
         && (wst < 2'd3 || $past(vld & ~rdy, 3)));

endmodule: tcb_mem

// ==== hw/tcb_pkg.sv ====
//////////////////////////////
// TCB subsystem definitions
// bus widths, address map, register offsets and the
// vector types shared by decoder, memory and registers
//////////////////////////////

package tcb_pkg;

//////////////////////////////
// bus widths
//////////////////////////////

  // byte address and data
  localparam int unsigned ABW = 16;
  localparam int unsigned DBW = 32;
  // one enable per byte lane
  localparam int unsigned BEW = DBW / 8;

//////////////////////////////
// address map
//////////////////////////////

  // memory, 256 words = 1 KiB
  localparam int unsigned MEM_WORDS = 256;
  localparam logic [ABW-1:0] MEM_BASE = 16'h0000;
  // byte address bits inside the memory region
  localparam int unsigned MEM_AW = 10;

  // register block, 4 words = 16 bytes
  localparam logic [ABW-1:0] CSR_BASE = 16'h1000;
  localparam int unsigned CSR_AW = 4;

  // register offsets inside the block
  localparam logic [CSR_AW-1:0] CSR_CTRL = 4'h0;
  localparam logic [CSR_AW-1:0] CSR_WPL  = 4'h4;
  localparam logic [CSR_AW-1:0] CSR_ERRC = 4'h8;

//////////////////////////////
// vector types
//////////////////////////////

  typedef logic [ABW-1:0] adr_t;
  typedef logic [DBW-1:0] dat_t;
  typedef logic [BEW-1:0] ben_t;
  // word index into memory, address bits 9:2
  typedef logic [$clog2(MEM_WORDS)-1:0] wix_t;
  // 0 to 3 wait states
  typedef logic [1:0] wst_t;

endpackage: tcb_pkg

// ==== hw/tcb_sys.sv ====
//////////////////////////////
// TCB subordinate subsystem
// decoder with memory and register block
//////////////////////////////

`timescale 1ns/10ps

module tcb_sys import tcb_pkg::*; (
  input  logic tcb,
  input  logic rst_n,
  // request
  input  logic vld,
  input  logic wen,
  input  adr_t adr,
  input  ben_t ben,
  input  dat_t wdt,
  output logic rdy,
  // response
  output logic rsp,
  output dat_t rdt,
  output logic err
);

  // per target handshake
  logic mem_vld;
  logic mem_rdy;
  logic csr_vld;
  logic csr_rdy;
  // per target response
  logic mem_rsp;
  dat_t mem_rdt;
  logic mem_err;
  logic csr_rsp;
  dat_t csr_rdt;
  // register controls and error pulse
  wst_t wst;
  wix_t wpl;
  logic err_evt;

//////////////////////////////
// decoder
//////////////////////////////

  tcb_dec i_dec (
    .tcb     (tcb),
    .rst_n   (rst_n),
    .vld     (vld),
    .wen     (wen),
    .adr     (adr),
    .mem_vld (mem_vld),
    .csr_vld (csr_vld),
    .mem_rdy (mem_rdy),
    .csr_rdy (csr_rdy),
    .mem_rsp (mem_rsp),
    .mem_rdt (mem_rdt),
    .mem_err (mem_err),
    .csr_rsp (csr_rsp),
    .csr_rdt (csr_rdt),
    .rdy     (rdy),
    .rsp     (rsp),
    .rdt     (rdt),
    .err     (err),
    .err_evt (err_evt)
  );

//////////////////////////////
// targets
//////////////////////////////

  // wen, adr, ben, wdt shared by both
  tcb_mem i_mem (
    .tcb   (tcb),
    .rst_n (rst_n),
    .vld   (mem_vld),
    .wen   (wen),
    .adr   (adr),
    .ben   (ben),
    .wdt   (wdt),
    .rdy   (mem_rdy),
    .wst   (wst),
    .wpl   (wpl),
    .rsp   (mem_rsp),
    .rdt   (mem_rdt),
    .err   (mem_err)
  );

  tcb_csr i_csr (
    .tcb     (tcb),
    .rst_n   (rst_n),
    .vld     (csr_vld),
    .wen     (wen),
    .adr     (adr),
    .ben     (ben),
    .wdt     (wdt),
    .rdy     (csr_rdy),
    .rsp     (csr_rsp),
    .rdt     (csr_rdt),
    .wst     (wst),
    .wpl     (wpl),
    .err_evt (err_evt)
  );

endmodule: tcb_sys

// ==== list.f ====
hw/tcb_pkg.sv
hw/tcb_dec.sv
hw/tcb_mem.sv
hw/tcb_csr.sv
hw/tcb_sys.sv
test/tcb_sys_tb.sv

// ==== test/tcb_sys_tb.sv ====
//////////////////////////////
// TCB subsystem testbench
// random manager with a reference model of memory,
// registers and the error count
//////////////////////////////

`timescale 1ns/10ps

module tcb_sys_tb import tcb_pkg::*;;

  logic tcb;
  logic rst_n;
  logic vld;
  logic wen;
  adr_t adr;
  ben_t ben;
  dat_t wdt;
  logic rdy;
  logic rsp;
  dat_t rdt;
  logic err;

  integer seed;
  // transfer seen at the last rising edge
  logic trn_q = 1'b0;

  // reference model
  dat_t m_mem [MEM_WORDS];
  wst_t m_wst;
  wix_t m_wpl;
  dat_t m_errc;

  tcb_sys i_dut (
    .tcb   (tcb),
    .rst_n (rst_n),
    .vld   (vld),
    .wen   (wen),
    .adr   (adr),
    .ben   (ben),
    .wdt   (wdt),
    .rdy   (rdy),
    .rsp   (rsp),
    .rdt   (rdt),
    .err   (err)
  );

  initial begin
    tcb = 1'b0;
    forever #50 tcb = ~tcb;
  end

  always @(posedge tcb) begin
    trn_q <= vld & rdy;
  end

  function automatic int unsigned urand(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  task automatic compare(input string name, input dat_t exp, input dat_t act);
    if (exp !== act) begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      $display("test failed");
      $fatal(1);
    end
  endtask

  // rsp high exactly in the cycle after each transfer
  always @(negedge tcb) begin
    if (rst_n) compare("rsp_timing", dat_t'(trn_q), dat_t'(rsp));
  end

//////////////////////////////
// reference model
//////////////////////////////

  task automatic predict(input logic w, input adr_t a, input ben_t b, input dat_t d,
                         output int wt, output dat_t ex_rdt, output logic ex_err);
    wix_t ix;
    logic [1:0] off;
    ix = a[9:2];
    off = a[3:2];
    wt = 0;
    ex_rdt = '0;
    ex_err = 1'b0;
    if (a[15:10] == 6'h00) begin
      // memory, stalls for wst cycles
      wt = int'(m_wst);
      if (w && ix < m_wpl) begin
        ex_err = 1'b1;
      end else if (w) begin
        for (int i = 0; i < 4; i++) begin
          if (b[i]) m_mem[ix][8*i +: 8] = d[8*i +: 8];
        end
      end else begin
        ex_rdt = m_mem[ix];
      end
    end else if (a[15:4] == 12'h100) begin
      // registers, fields in byte lane 0
      if (w) begin
        case (off)
          2'd0: if (b[0]) m_wst = d[1:0];
          2'd1: if (b[0]) m_wpl = d[7:0];
          2'd2: ex_err = 1'b1;
          default: ;
        endcase
      end else begin
        case (off)
          2'd0: ex_rdt = {30'd0, m_wst};
          2'd1: ex_rdt = {24'd0, m_wpl};
          2'd2: ex_rdt = m_errc;
          default: ex_rdt = '0;
        endcase
      end
    end else begin
      // unmapped
      ex_err = 1'b1;
    end
    if (ex_err) m_errc = m_errc + 32'd1;
  endtask

//////////////////////////////
// manager
//////////////////////////////

  // entered on a falling edge, left on the falling edge of the response cycle
  task automatic transfer(input string name, input logic w, input adr_t a, input ben_t b,
                          input dat_t d);
    int wt;
    int waits;
    dat_t ex_rdt;
    logic ex_err;
    predict(w, a, b, d, wt, ex_rdt, ex_err);
    vld = 1'b1;
    wen = w;
    adr = a;
    ben = b;
    wdt = d;
    waits = 0;
    @(negedge tcb);
    while (!trn_q) begin
      waits++;
      if (waits > 8) begin
        $display("timeout, rdy never rose for address %h", a);
        $display("test failed");
        $fatal(1);
      end
      @(negedge tcb);
    end
    compare({name, " wait"}, dat_t'(wt), dat_t'(waits));
    compare({name, " rsp"}, 32'd1, dat_t'(rsp));
    compare({name, " err"}, dat_t'(ex_err), dat_t'(err));
    if (!w) compare({name, " rdt"}, ex_rdt, rdt);
  endtask

  // zero cycles keeps requests back to back
  task automatic gap();
    int n;
    n = int'(urand(3));
    if (n > 0) begin
      vld = 1'b0;
      adr = adr_t'(urand(65536));
      repeat (n) @(negedge tcb);
    end
  endtask

  initial begin
    int op;
    adr_t a;
    seed = 32'hd532766d;
    rst_n = 1'b0;
    vld = 1'b0;
    wen = 1'b0;
    adr = '0;
    ben = '0;
    wdt = '0;
    m_wst = '0;
    m_wpl = '0;
    m_errc = '0;
    for (int i = 0; i < MEM_WORDS; i++) m_mem[i] = '0;
    repeat (3) @(posedge tcb);
    @(negedge tcb);
    rst_n = 1'b1;
    // clear every word through the bus
    for (int i = 0; i < MEM_WORDS; i++) begin
      transfer("zero_fill", 1'b1, adr_t'(i * 4), 4'hf, '0);
    end
    for (int r = 0; r < 10; r++) begin
      // new wait states and protection limit each round
      transfer("ctrl_wr", 1'b1, CSR_BASE, ben_t'(urand(16)), dat_t'($random(seed)));
      transfer("wpl_wr", 1'b1, CSR_BASE + 16'h4, ben_t'(urand(16)),
               dat_t'($random(seed)) & 32'hffff_ff3f);
      gap();
      for (int k = 0; k < 40; k++) begin
        op = int'(urand(7));
        if (op < 2) begin
          a = adr_t'(urand(MEM_WORDS) * 4);
          transfer("mem_wr", 1'b1, a, ben_t'(urand(16)), dat_t'($random(seed)));
          if (urand(2) == 0) transfer("mem_rd_back", 1'b0, a, '0, '0);
        end else if (op < 4) begin
          transfer("mem_rd", 1'b0, adr_t'(urand(MEM_WORDS) * 4), '0, '0);
        end else if (op == 4) begin
          transfer("csr_rd", 1'b0, CSR_BASE + adr_t'(urand(4) * 4), '0, '0);
        end else if (op == 5) begin
          transfer("errc_wr", 1'b1, CSR_BASE + 16'h8, 4'hf, dat_t'($random(seed)));
        end else begin
          a = adr_t'(urand(65536));
          // push mapped picks out of both regions
          if (a[15:10] == 6'h00 || a[15:4] == 12'h100) a[15] = 1'b1;
          transfer("unmapped", urand(2) == 0, a, 4'hf, dat_t'($random(seed)));
        end
        gap();
      end
    end
    transfer("errc_final", 1'b0, CSR_BASE + 16'h8, '0, '0);
    transfer("ctrl_final", 1'b0, CSR_BASE, '0, '0);
    transfer("wpl_final", 1'b0, CSR_BASE + 16'h4, '0, '0);
    vld = 1'b0;
    @(negedge tcb);
    $display("test passed");
    $finish;
  end

endmodule: tcb_sys_tb
